// ==== Makefile ====
OBJ_DIR = obj_dir
SIM_LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --top-module tb_uart_cmd \
		-f project.f -Mdir $(OBJ_DIR) -o sim_uart_cmd

run: compile
	./$(OBJ_DIR)/sim_uart_cmd | tee $(SIM_LOG)
	grep -q "Everything OK" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== hdl/cmd_framer.sv ====
`timescale 1ns/10ps

module cmd_framer (
  input  logic               clk,
  input  logic               rst_n,
  input  cmd_pkg::cmd_t      cmd,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output logic               tx_start,
  output uart_pkg::tx_byte_t tx_byte,
  input  logic               tx_done
);
  import cmd_pkg::*;

  framer_state_e state;
  framer_state_e state_nxt;
  cmd_t          cmd_q;

  assign cmd_rdy  = (state == st_idle);
  assign tx_start = (state == st_send_hi) || (state == st_send_lo);

  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy) begin
      cmd_q <= cmd;
    end
  end

  // high byte is op and address; a read ends there
  always_comb begin
    if (state == st_send_lo || state == st_wait_lo) begin
      tx_byte.data = cmd_q.data;
      tx_byte.last = 1'b1;
    end else begin
      tx_byte.data = {cmd_q.op, cmd_q.addr};
      tx_byte.last = (cmd_q.op == op_read);
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (cmd_vld) state_nxt = st_send_hi;
      end
      st_send_hi: state_nxt = st_wait_hi;
      st_wait_hi: begin
        if (tx_done) state_nxt = tx_byte.last ? st_idle : st_send_lo;
      end
      st_send_lo: state_nxt = st_wait_lo;
      st_wait_lo: begin
        if (tx_done) state_nxt = st_idle;
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // serializer gets no new byte until its frame is out
  a_no_overlap: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |=> (!tx_start throughout tx_done [->1])
  );

endmodule

// ==== hdl/cmd_pkg.sv ====
package cmd_pkg;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cmd_op_e;

  // upper byte is op and address, lower byte is write data
  typedef struct packed {
    cmd_op_e    op;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  typedef enum logic [2:0] {
    st_idle,
    st_send_hi,
    st_wait_hi,
    st_send_lo,
    st_wait_lo
  } framer_state_e;

endpackage

// ==== hdl/uart_cmd_top.sv ====
`timescale 1ns/10ps

module uart_cmd_top #(
  parameter int clk_div    = uart_pkg::clk_div_default,
  parameter bit parity_odd = 1'b1
) (
  input  logic          clk,
  input  logic          rst_n,
  input  cmd_pkg::cmd_t cmd,
  input  logic          cmd_vld,
  output logic          cmd_rdy,
  input  logic          rx,
  output logic          tx,
  output logic          read_vld,
  output logic [7:0]    read_data,
  output logic          rx_err
);
  import uart_pkg::*;

  logic       tx_start;
  logic       tx_done;
  tx_byte_t   tx_byte;
  logic       rx_vld;
  rx_result_t rx_result;
  logic       rx_bad;

  cmd_framer cmd_framer_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done)
  );

  uart_tx #(
    .clk_div    (clk_div),
    .parity_odd (parity_odd)
  ) uart_tx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx #(
    .clk_div    (clk_div),
    .parity_odd (parity_odd)
  ) uart_rx_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_vld    (rx_vld),
    .rx_result (rx_result)
  );

  // a frame with either flag set is an error, not a read
  assign rx_bad    = rx_result.parity_bad || rx_result.stop_bad;
  assign read_vld  = rx_vld && !rx_bad;
  assign rx_err    = rx_vld && rx_bad;
  assign read_data = rx_result.data;

endmodule

// ==== hdl/uart_pkg.sv ====
package uart_pkg;

  // cycles per bit, 115200 baud from a 50 MHz clock
  localparam int clk_div_default = 434;

  // start, eight data bits, parity, stop
  localparam int frame_bits = 11;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } tx_byte_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_bad;
    logic       stop_bad;
  } rx_result_t;

  // bit that makes the count of ones over data plus parity odd
  function automatic logic odd_parity(input logic [7:0] data);
    return ~^data;
  endfunction

endpackage

// ==== hdl/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx #(
  parameter int clk_div    = uart_pkg::clk_div_default,
  parameter bit parity_odd = 1'b1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic                 rx_vld,
  output uart_pkg::rx_result_t rx_result
);
  import uart_pkg::*;

  localparam int div_w = $clog2(clk_div + 1);

  logic [1:0]       sync;
  logic             rx_q;
  logic             rx_s;
  logic             fall;
  logic             active;
  logic [div_w-1:0] div_cnt;
  logic [div_w-1:0] lim;
  logic [3:0]       bit_cnt;
  logic             mid;
  logic [7:0]       data_sh;
  logic             par_bit;
  logic             par_exp;

  assign rx_s = sync[1];
  assign fall = rx_q && !rx_s;

  // half a bit to the start midpoint, a full bit after that
  assign lim     = (bit_cnt == 4'd0) ? div_w'(clk_div / 2 - 1) : div_w'(clk_div - 1);
  assign mid     = active && (div_cnt == lim);
  assign par_exp = parity_odd ? odd_parity(data_sh) : ~odd_parity(data_sh);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync <= 2'b11;
      rx_q <= 1'b1;
    end else begin
      sync <= {sync[0], rx};
      rx_q <= rx_s;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active  <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      rx_vld  <= 1'b0;
    end else begin
      rx_vld <= 1'b0;
      if (!active) begin
        if (fall) begin
          active  <= 1'b1;
          div_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (mid) begin
        div_cnt <= '0;
        bit_cnt <= bit_cnt + 4'd1;
        // glitch rather than a start bit
        if (bit_cnt == 4'd0 && rx_s) begin
          active <= 1'b0;
        end
        if (bit_cnt == 4'(frame_bits - 1)) begin
          active <= 1'b0;
          rx_vld <= 1'b1;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mid && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
      data_sh <= {rx_s, data_sh[7:1]};
    end
    if (mid && bit_cnt == 4'd9) begin
      par_bit <= rx_s;
    end
    if (mid && bit_cnt == 4'(frame_bits - 1)) begin
      rx_result.data       <= data_sh;
      rx_result.parity_bad <= (par_bit != par_exp);
      rx_result.stop_bad   <= !rx_s;
    end
  end

  // one strobe per frame, the next frame needs a fresh start bit
  a_vld_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) rx_vld |=> !rx_vld
  );

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx #(
  parameter int clk_div    = uart_pkg::clk_div_default,
  parameter bit parity_odd = 1'b1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               tx_start,
  input  uart_pkg::tx_byte_t tx_byte,
  output logic               tx_done,
  output logic               tx
);
  import uart_pkg::*;

  localparam int div_w = $clog2(clk_div + 1);

  logic [frame_bits-1:0] shreg;
  logic [div_w-1:0]      div_cnt;
  logic [3:0]            bit_cnt;
  logic                  busy;
  logic                  par;
  logic                  bit_end;

  assign par     = parity_odd ? odd_parity(tx_byte.data) : ~odd_parity(tx_byte.data);
  assign bit_end = busy && (div_cnt == div_w'(clk_div - 1));
  assign tx_done = bit_end && (bit_cnt == 4'(frame_bits - 1));

  // line is the low end of the shift register, ones fill in behind
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg <= '1;
    end else if (tx_start) begin
      shreg <= {1'b1, par, tx_byte.data, 1'b0};
    end else if (bit_end) begin
      shreg <= {1'b1, shreg[frame_bits-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (tx_start) begin
      busy    <= 1'b1;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (tx_done) begin
      busy    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (bit_end) begin
      div_cnt <= '0;
      bit_cnt <= bit_cnt + 4'd1;
    end else if (busy) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // divider wraps one short of clk_div on every bit
  a_div_range: assert property (
    @(posedge clk) disable iff (!rst_n) div_cnt < div_w'(clk_div)
  );

endmodule

// ==== project.f ====
hdl/uart_pkg.sv
hdl/cmd_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/cmd_framer.sv
hdl/uart_cmd_top.sv
sim/tb_uart_cmd.sv

// ==== sim/tb_uart_cmd.sv ====
`timescale 1ns/10ps

module tb_uart_cmd;
  import cmd_pkg::*;

  localparam int clk_div = 8;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  logic       read_vld;
  logic [7:0] read_data;
  logic       rx_err;

  logic [15:0] lfsr_state;
  logic [10:0] exp_frames[$];
  // bit 8 set for a byte that should come back as an error
  logic [8:0]  exp_rx[$];

  uart_cmd_top #(
    .clk_div    (clk_div),
    .parity_odd (1'b1)
  ) uart_cmd_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_vld  (read_vld),
    .read_data (read_data),
    .rx_err    (rx_err)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
  endtask

  // parity bit that leaves an odd number of ones over nine bits
  function automatic logic expected_parity(input logic [7:0] b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) ones++;
    end
    return (ones % 2 == 0);
  endfunction

  function automatic int expected_frames(input cmd_t c, output logic [10:0] hi_f,
                                         output logic [10:0] lo_f);
    logic [7:0] hi_b;
    hi_b = {c.op, c.addr};
    hi_f = {1'b1, expected_parity(hi_b), hi_b, 1'b0};
    lo_f = {1'b1, expected_parity(c.data), c.data, 1'b0};
    return (c.op == op_write) ? 2 : 1;
  endfunction

  task automatic run_cmd(input cmd_op_e op, input bit noise);
    cmd_t        c;
    logic [15:0] r;
    logic [10:0] hi_f;
    logic [10:0] lo_f;
    int          n;
    int          cycles;
    int          exp_lat;
    take_bits(15, r);
    c.op   = op;
    c.addr = r[14:8];
    c.data = r[7:0];
    n = expected_frames(c, hi_f, lo_f);
    exp_frames.push_back(hi_f);
    if (n == 2) exp_frames.push_back(lo_f);
    exp_lat = (op == op_write) ? 22 * clk_div + 3 : 11 * clk_div + 2;
    cycles = 0;
    while (cmd_rdy !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 50) abort_run("cmd_rdy stayed low before a new command");
    end
    cmd     = c;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    cycles  = 1;
    check_eq("cmd_rdy", 32'(cmd_rdy), 32'(0));
    while (cmd_rdy !== 1'b1) begin
      if (cycles > exp_lat + 20) abort_run("cmd_rdy never rose after a command");
      // stray commands while busy must be dropped
      if (noise && cycles < 8 * clk_div) begin
        take_bits(16, r);
        cmd     = cmd_t'(r);
        cmd_vld = cycles[0];
      end else begin
        cmd_vld = 1'b0;
      end
      @(negedge clk);
      cycles++;
    end
    check_eq("cmd latency", 32'(cycles), 32'(exp_lat));
    check_eq("frames left", 32'(exp_frames.size()), 32'(0));
  endtask

  task automatic drive_rx(input logic [7:0] b, input bit flip_par, input bit low_stop);
    logic [10:0] f;
    int          cycles;
    f = {~low_stop, expected_parity(b) ^ flip_par, b, 1'b0};
    exp_rx.push_back({flip_par | low_stop, b});
    for (int i = 0; i < 11; i++) begin
      rx = f[i];
      repeat (clk_div) @(negedge clk);
    end
    rx = 1'b1;
    cycles = 0;
    while (exp_rx.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > 4 * clk_div) abort_run("receiver gave no strobe for a byte");
    end
    repeat (clk_div) @(negedge clk);
  endtask

  // samples tx at mid-bit and checks each frame against the queue
  initial begin : tx_monitor
    logic [10:0] got;
    logic [10:0] exp;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && tx === 1'b0) begin
        repeat (clk_div / 2) @(negedge clk);
        got[0] = tx;
        for (int i = 1; i < 11; i++) begin
          repeat (clk_div) @(negedge clk);
          got[i] = tx;
        end
        if (exp_frames.size() == 0) abort_run("frame on tx with no command pending");
        exp = exp_frames.pop_front();
        check_eq("tx frame", 32'(got), 32'(exp));
      end
    end
  end

  initial begin : rx_checker
    logic [8:0] e;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && (read_vld === 1'b1 || rx_err === 1'b1)) begin
        if (exp_rx.size() == 0) abort_run("read_vld or rx_err pulsed with no byte sent");
        e = exp_rx.pop_front();
        check_eq("rx_err", 32'(rx_err), 32'(e[8]));
        check_eq("read_vld", 32'(read_vld), 32'(!e[8]));
        if (!e[8]) check_eq("read_data", 32'(read_data), 32'(e[7:0]));
      end
    end
  end

  initial begin : main
    logic [15:0] r;
    lfsr_state = 16'd9259;
    rst_n      = 1'b0;
    cmd        = '0;
    cmd_vld    = 1'b0;
    rx         = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("tx", 32'(tx), 32'(1));
    check_eq("cmd_rdy", 32'(cmd_rdy), 32'(1));
    check_eq("read_vld", 32'(read_vld), 32'(0));
    check_eq("rx_err", 32'(rx_err), 32'(0));

    repeat (3) run_cmd(op_write, 1'b0);
    repeat (3) run_cmd(op_read, 1'b0);
    run_cmd(op_write, 1'b1);
    run_cmd(op_read, 1'b1);

    repeat (6) begin
      take_bits(8, r);
      drive_rx(r[7:0], 1'b0, 1'b0);
    end
    take_bits(8, r);
    drive_rx(r[7:0], 1'b1, 1'b0);
    take_bits(8, r);
    drive_rx(r[7:0], 1'b0, 1'b1);
    // receiver must recover after the bad frames
    take_bits(8, r);
    drive_rx(r[7:0], 1'b0, 1'b0);

    $display("Everything OK");
    $finish;
  end

endmodule
